// ==== include/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// data path width.
`define XLEN 32

// memory depths in words.
`define DMEM_WORDS 1024
`define IMEM_WORDS 1024

// byte offset bits below the word index.
`define WORD_LSB 2

// bit 16 low is data memory, high is the peripheral space.
`define REGION_BIT 16

// peripheral select field.
`define SEL_MSB 15
`define SEL_LSB 13

// gpio pin count.
`define GPIO_W 16

`endif

// ==== design/soc_pkg.sv ====
package soc_pkg;

    // peripheral slot, taken from the select field when bit 16 is high.
    typedef enum logic [2:0] {
        PSEL_UART  = 3'd0,
        PSEL_I2C   = 3'd1,
        PSEL_QSPI  = 3'd2,
        PSEL_TIMER = 3'd3,
        PSEL_USB   = 3'd4,
        PSEL_GPIO  = 3'd5,
        PSEL_IMEM0 = 3'd6,
        PSEL_IMEM1 = 3'd7
    } periph_sel_e;

    // timer word offsets, address bits 3:2.
    typedef enum logic [1:0] {
        TMR_CTRL    = 2'd0,
        TMR_COUNT   = 2'd1,
        TMR_COMPARE = 2'd2,
        TMR_STATUS  = 2'd3
    } timer_reg_e;

    // gpio word offset, address bit 2.
    typedef enum logic [0:0] {
        GPIO_OUT = 1'b0,
        GPIO_IN  = 1'b1
    } gpio_reg_e;

endpackage

// ==== design/data_mem.sv ====
`include "soc_config.svh"

module data_mem (
    input  logic                            clk_i,
    input  logic                            we_i,
    input  logic [`XLEN/8-1:0]              be_i,
    input  logic [$clog2(`DMEM_WORDS)-1:0]  addr_i,
    input  logic [`XLEN-1:0]                wdata_i,
    output logic [`XLEN-1:0]                rdata_o
);

    localparam int NB = `XLEN / 8;

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    // byte lanes written independently.
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < NB; i++) begin
                if (be_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[addr_i]; // async read, bus registers it.

endmodule

// ==== design/instr_mem.sv ====
`include "soc_config.svh"

module instr_mem (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // fetch port.
    input  logic                            fetch_req_i,
    input  logic [$clog2(`IMEM_WORDS)-1:0]  fetch_addr_i,
    output logic                            fetch_gnt_o,
    output logic                            fetch_rvalid_o,
    output logic [`XLEN-1:0]                fetch_rdata_o,
    // write port from the data bus.
    input  logic                            wr_en_i,
    input  logic [$clog2(`IMEM_WORDS)-1:0]  wr_addr_i,
    input  logic [`XLEN-1:0]                wr_data_i
);

    logic [`XLEN-1:0] mem [`IMEM_WORDS];

    assign fetch_gnt_o = fetch_req_i; // never stalls.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fetch_rvalid_o <= 1'b0;
        end else begin
            fetch_rvalid_o <= fetch_req_i;
        end
    end

    // read and write share the edge, so a colliding fetch sees the old word.
    always_ff @(posedge clk_i) begin
        if (fetch_req_i) begin
            fetch_rdata_o <= mem[fetch_addr_i];
        end
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i; // whole word, no byte enables.
        end
    end

endmodule

// ==== design/timer.sv ====
`include "soc_config.svh"

module timer (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                we_i,
    input  logic [`XLEN/8-1:0]  be_i,
    input  logic [1:0]          addr_i,
    input  logic [`XLEN-1:0]    wdata_i,
    input  logic                irq_ack_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                irq_o
);
    import soc_pkg::*;

    localparam int NB = `XLEN / 8;

    function automatic logic [`XLEN-1:0] merge_bytes(
        input logic [`XLEN-1:0] old_v,
        input logic [`XLEN-1:0] new_v,
        input logic [NB-1:0]    be
    );
        logic [`XLEN-1:0] res;
        res = old_v;
        for (int i = 0; i < NB; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    timer_reg_e       reg_sel;
    logic [1:0]       ctrl_q;    // bit 0 enable, bit 1 irq enable.
    logic [`XLEN-1:0] count_q;
    logic [`XLEN-1:0] compare_q;
    logic             pending_q;
    logic             match;

    assign reg_sel = timer_reg_e'(addr_i);
    assign match   = ctrl_q[0] && (count_q == compare_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q <= '0;
        end else if (we_i && reg_sel == TMR_CTRL && be_i[0]) begin
            ctrl_q <= wdata_i[1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (we_i && reg_sel == TMR_COUNT) begin
            count_q <= merge_bytes(count_q, wdata_i, be_i); // load wins over counting.
        end else if (match) begin
            count_q <= '0;
        end else if (ctrl_q[0]) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            compare_q <= '0;
        end else if (we_i && reg_sel == TMR_COMPARE) begin
            compare_q <= merge_bytes(compare_q, wdata_i, be_i);
        end
    end

    // a new match beats the acknowledge.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else if (match) begin
            pending_q <= 1'b1;
        end else if (irq_ack_i) begin
            pending_q <= 1'b0;
        end
    end

    always_comb begin
        case (reg_sel)
            TMR_CTRL:    rdata_o = {{(`XLEN-2){1'b0}}, ctrl_q};
            TMR_COUNT:   rdata_o = count_q;
            TMR_COMPARE: rdata_o = compare_q;
            TMR_STATUS:  rdata_o = {{(`XLEN-1){1'b0}}, pending_q};
            default:     rdata_o = '0;
        endcase
    end

    assign irq_o = pending_q & ctrl_q[1]; // level irq.

endmodule

// ==== design/gpio.sv ====
`include "soc_config.svh"

module gpio (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  we_i,
    input  logic [`GPIO_W/8-1:0]  be_i,
    input  logic [0:0]            addr_i,
    input  logic [`GPIO_W-1:0]    wdata_i,
    input  logic [`GPIO_W-1:0]    pins_i,
    output logic [`XLEN-1:0]      rdata_o,
    output logic [`GPIO_W-1:0]    pins_o
);
    import soc_pkg::*;

    localparam int NB = `GPIO_W / 8;

    gpio_reg_e          reg_sel;
    logic [`GPIO_W-1:0] out_q;

    assign reg_sel = gpio_reg_e'(addr_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_q <= '0;
        end else if (we_i && reg_sel == GPIO_OUT) begin
            for (int i = 0; i < NB; i++) begin
                if (be_i[i]) begin
                    out_q[8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    assign pins_o = out_q;

    // input pins are read unsynchronized.
    always_comb begin
        case (reg_sel)
            GPIO_OUT: rdata_o = {{(`XLEN-`GPIO_W){1'b0}}, out_q};
            GPIO_IN:  rdata_o = {{(`XLEN-`GPIO_W){1'b0}}, pins_i};
            default:  rdata_o = '0;
        endcase
    end

endmodule

// ==== design/periph_bus.sv ====
`include "soc_config.svh"

module periph_bus (
    input  logic                clk_i,
    input  logic                rst_i,
    // data port.
    input  logic                data_req_i,
    input  logic                data_we_i,
    input  logic [`XLEN/8-1:0]  data_be_i,
    input  logic [`XLEN-1:0]    data_addr_i,
    input  logic [`XLEN-1:0]    data_wdata_i,
    output logic                data_gnt_o,
    output logic                data_rvalid_o,
    output logic [`XLEN-1:0]    data_rdata_o,
    // instruction fetch port.
    input  logic                instr_req_i,
    input  logic [`XLEN-1:0]    instr_addr_i,
    output logic                instr_gnt_o,
    output logic                instr_rvalid_o,
    output logic [`XLEN-1:0]    instr_rdata_o,
    // timer interrupt.
    input  logic                irq_ack_i,
    output logic                irq_o,
    // pins.
    input  logic [`GPIO_W-1:0]  gpio_i,
    output logic [`GPIO_W-1:0]  gpio_o
);
    import soc_pkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);
    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    periph_sel_e      periph_sel;
    logic             wr;
    logic             dmem_sel, timer_sel, gpio_sel, imem_sel;
    logic [`XLEN-1:0] dmem_rdata, timer_rdata, gpio_rdata;
    logic [`XLEN-1:0] rdata_nxt;

    assign data_gnt_o = 1'b1;
    assign wr         = data_req_i & data_we_i;
    assign periph_sel = periph_sel_e'(data_addr_i[`SEL_MSB:`SEL_LSB]);
    assign dmem_sel   = ~data_addr_i[`REGION_BIT]; // straight from the region bit.

    always_comb begin
        timer_sel = 1'b0;
        gpio_sel  = 1'b0;
        imem_sel  = 1'b0;
        if (data_addr_i[`REGION_BIT]) begin
            case (periph_sel)
                PSEL_TIMER:             timer_sel = 1'b1;
                PSEL_GPIO:              gpio_sel  = 1'b1;
                PSEL_IMEM0, PSEL_IMEM1: imem_sel  = 1'b1;
                // empty slots, read as zero.
                PSEL_UART, PSEL_I2C, PSEL_QSPI, PSEL_USB: ;
                default: ;
            endcase
        end
    end

    data_mem i_data_mem (
        .clk_i   (clk_i),
        .we_i    (wr & dmem_sel),
        .be_i    (data_be_i),
        .addr_i  (data_addr_i[DMEM_AW+`WORD_LSB-1:`WORD_LSB]),
        .wdata_i (data_wdata_i),
        .rdata_o (dmem_rdata)
    );

    instr_mem i_instr_mem (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_req_i    (instr_req_i),
        .fetch_addr_i   (instr_addr_i[IMEM_AW+`WORD_LSB-1:`WORD_LSB]),
        .fetch_gnt_o    (instr_gnt_o),
        .fetch_rvalid_o (instr_rvalid_o),
        .fetch_rdata_o  (instr_rdata_o),
        .wr_en_i        (wr & imem_sel),
        .wr_addr_i      (data_addr_i[IMEM_AW+`WORD_LSB-1:`WORD_LSB]),
        .wr_data_i      (data_wdata_i)
    );

    timer i_timer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .we_i      (wr & timer_sel),
        .be_i      (data_be_i),
        .addr_i    (data_addr_i[3:2]),
        .wdata_i   (data_wdata_i),
        .irq_ack_i (irq_ack_i),
        .rdata_o   (timer_rdata),
        .irq_o     (irq_o)
    );

    gpio i_gpio (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .we_i    (wr & gpio_sel),
        .be_i    (data_be_i[`GPIO_W/8-1:0]),
        .addr_i  (data_addr_i[2]),
        .wdata_i (data_wdata_i[`GPIO_W-1:0]),
        .pins_i  (gpio_i),
        .rdata_o (gpio_rdata),
        .pins_o  (gpio_o)
    );

    // instr memory has no data-side read path.
    assign rdata_nxt = ({`XLEN{dmem_sel}}  & dmem_rdata)
                     | ({`XLEN{timer_sel}} & timer_rdata)
                     | ({`XLEN{gpio_sel}}  & gpio_rdata);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_rvalid_o <= 1'b0;
            data_rdata_o  <= '0;
        end else begin
            data_rvalid_o <= data_req_i; // writes get rvalid too.
            data_rdata_o  <= rdata_nxt;
        end
    end

endmodule

// ==== verification/tb_periph_bus.sv ====
`include "soc_config.svh"

module tb_periph_bus;
    import soc_pkg::*;

    localparam int CLK_HALF = 4;
    localparam int SEED     = 32'h6b05ee03;

    logic               clk_i;
    logic               rst_i;
    logic               data_req_i;
    logic               data_we_i;
    logic [`XLEN/8-1:0] data_be_i;
    logic [`XLEN-1:0]   data_addr_i;
    logic [`XLEN-1:0]   data_wdata_i;
    logic               data_gnt_o;
    logic               data_rvalid_o;
    logic [`XLEN-1:0]   data_rdata_o;
    logic               instr_req_i;
    logic [`XLEN-1:0]   instr_addr_i;
    logic               instr_gnt_o;
    logic               instr_rvalid_o;
    logic [`XLEN-1:0]   instr_rdata_o;
    logic               irq_ack_i;
    logic               irq_o;
    logic [`GPIO_W-1:0] gpio_i;
    logic [`GPIO_W-1:0] gpio_o;

    // reference copies of the memories and the gpio output register.
    logic [`XLEN-1:0]   dmem_model [`DMEM_WORDS];
    logic [`XLEN-1:0]   imem_model [`IMEM_WORDS];
    logic [`GPIO_W-1:0] gpio_model;
    int unsigned        dmem_used [$]; // words fully written at least once.
    int unsigned        imem_known;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;

    periph_bus i_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .irq_ack_i      (irq_ack_i),
        .irq_o          (irq_o),
        .gpio_i         (gpio_i),
        .gpio_o         (gpio_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    function automatic logic [31:0] periph_addr(input periph_sel_e sel, input logic [12:0] offs);
        return {15'h0, 1'b1, sel, offs}; // bit 16 set, select in 15:13.
    endfunction

    function automatic logic [31:0] dmem_addr(input int unsigned idx);
        logic [3:0] upper;
        upper = 4'($urandom); // bits 15:12 do not reach the memory.
        return {16'h0, upper, 10'(idx), 2'b00};
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start_errs);
        tests_run++;
        if (errors == start_errs) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errs);
        end
    endtask

    task automatic drive_data_idle();
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
    endtask

    // one quiet cycle on both ports.
    task automatic idle_cycle();
        drive_data_idle();
        instr_req_i = 1'b0;
        @(negedge clk_i);
        if (data_rvalid_o !== 1'b0) report_error("data_rvalid_o high without a request");
        if (data_gnt_o !== 1'b1) report_error("data_gnt_o dropped");
        if (instr_rvalid_o !== 1'b0) report_error("instr_rvalid_o high without a fetch");
        if (instr_gnt_o !== 1'b0) report_error("instr_gnt_o high without a fetch");
    endtask

    task automatic access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_be_i    = be;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        @(negedge clk_i); // response registered on the edge just passed.
        if (data_rvalid_o !== 1'b1) report_error($sformatf("no rvalid for access to %h", addr));
        if (data_gnt_o !== 1'b1) report_error("data_gnt_o dropped");
        rdata = data_rdata_o;
    endtask

    task automatic write_word(input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata);
        logic [31:0] unused_rd;
        access(1'b1, be, addr, wdata, unused_rd);
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] rdata);
        access(1'b0, 4'h0, addr, 32'h0, rdata);
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        read_word(addr, rd);
        if (rd !== exp) begin
            report_error($sformatf("%s at %h read %h, expected %h", what, addr, rd, exp));
        end
    endtask

    task automatic fetch_word(input int unsigned idx, output logic [31:0] rdata);
        instr_req_i  = 1'b1;
        instr_addr_i = {20'($urandom), 10'(idx), 2'b00};
        @(negedge clk_i);
        if (instr_gnt_o !== 1'b1) report_error("instr_gnt_o low during a fetch");
        if (instr_rvalid_o !== 1'b1) report_error("no instr_rvalid_o after a fetch");
        rdata = instr_rdata_o;
    endtask

    task automatic test_reset_strobes();
        logic [31:0] rd;
        bit          pattern [10];
        int          start_errs;
        start_errs = errors;
        pattern = '{1, 1, 0, 1, 0, 0, 1, 1, 1, 0};
        if (data_rvalid_o !== 1'b0 || instr_rvalid_o !== 1'b0) begin
            report_error("rvalid set after reset");
        end
        if (irq_o !== 1'b0) report_error("irq_o set after reset");
        if (gpio_o !== '0) report_error($sformatf("gpio_o is %h after reset", gpio_o));
        if (data_rdata_o !== '0) report_error("data_rdata_o not zero after reset");
        foreach (pattern[i]) begin
            if (pattern[i]) begin
                read_word(periph_addr(PSEL_GPIO, 13'h0), rd);
            end else begin
                idle_cycle();
            end
        end
        finish_test("reset and strobes", start_errs);
    endtask

    task automatic test_data_mem();
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        int unsigned idx;
        int          start_errs;
        start_errs = errors;
        // full words first so that every byte of the model is known.
        for (int i = 0; i < 24; i++) begin
            addr  = $urandom & 32'h0000_fffc;
            wdata = $urandom;
            idx   = addr[11:2];
            dmem_model[idx] = wdata;
            dmem_used.push_back(idx);
            write_word(4'hf, addr, wdata);
        end
        for (int i = 0; i < 64; i++) begin
            idx = dmem_used[$urandom_range(dmem_used.size() - 1)];
            if ($urandom_range(1) == 1) begin
                be    = 4'($urandom);
                wdata = $urandom;
                write_word(be, dmem_addr(idx), wdata);
                dmem_model[idx] = merge_lanes(dmem_model[idx], wdata, be);
            end else begin
                check_read(dmem_addr(idx), dmem_model[idx], "data memory");
            end
        end
        foreach (dmem_used[j]) begin
            check_read(dmem_addr(dmem_used[j]), dmem_model[dmem_used[j]], "data memory");
        end
        idle_cycle();
        finish_test("data memory", start_errs);
    endtask

    task automatic test_instr_mem();
        int unsigned idx [8];
        logic [31:0] wdata;
        logic [31:0] rd;
        int          start_errs;
        start_errs = errors;
        for (int i = 0; i < 8; i++) begin
            idx[i] = $urandom_range(`IMEM_WORDS - 1);
            wdata  = $urandom;
            imem_model[idx[i]] = wdata;
            // byte enables are random, the whole word is written anyway.
            write_word(4'($urandom), periph_addr((i % 2) ? PSEL_IMEM1 : PSEL_IMEM0,
                                                 {1'b0, 10'(idx[i]), 2'b00}), wdata);
        end
        idle_cycle();
        for (int i = 0; i < 8; i++) begin
            fetch_word(idx[i], rd);
            if (rd !== imem_model[idx[i]]) begin
                report_error($sformatf("fetch of word %0d read %h, expected %h",
                                       idx[i], rd, imem_model[idx[i]]));
            end
        end
        // fetch and data write to the same word in one cycle.
        instr_req_i  = 1'b1;
        instr_addr_i = {20'h0, 10'(idx[0]), 2'b00};
        wdata        = ~imem_model[idx[0]];
        write_word(4'hf, periph_addr(PSEL_IMEM0, {1'b0, 10'(idx[0]), 2'b00}), wdata);
        if (instr_rdata_o !== imem_model[idx[0]]) begin
            report_error("colliding fetch missed the old word");
        end
        imem_model[idx[0]] = wdata;
        drive_data_idle();
        fetch_word(idx[0], rd);
        if (rd !== wdata) begin
            report_error($sformatf("fetch after write read %h, expected %h", rd, wdata));
        end
        idle_cycle();
        imem_known = idx[1];
        finish_test("instruction memory", start_errs);
    endtask

    task automatic test_empty_slots();
        periph_sel_e empty [4];
        logic [31:0] rd;
        int unsigned didx;
        int          start_errs;
        start_errs = errors;
        empty = '{PSEL_UART, PSEL_I2C, PSEL_QSPI, PSEL_USB};
        didx  = dmem_used[0];
        foreach (empty[s]) begin
            read_word(periph_addr(empty[s], 13'($urandom) & 13'h1ffc), rd);
            if (rd !== 32'h0) report_error($sformatf("%s slot read %h", empty[s].name(), rd));
            write_word(4'hf, periph_addr(empty[s], {1'b0, 10'(didx), 2'b00}), $urandom);
            write_word(4'hf, periph_addr(empty[s], {1'b0, 10'(imem_known), 2'b00}), $urandom);
            write_word(4'hf, periph_addr(empty[s], 13'h0008), $urandom); // timer compare offset.
        end
        check_read(dmem_addr(didx), dmem_model[didx], "data memory");
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_COMPARE) << 2), 32'h0, "timer compare");
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_CTRL) << 2), 32'h0, "timer ctrl");
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_COUNT) << 2), 32'h0, "timer count");
        drive_data_idle();
        fetch_word(imem_known, rd);
        if (rd !== imem_model[imem_known]) report_error("instruction word changed by empty slot");
        if (gpio_o !== gpio_model) report_error("gpio_o changed by empty slot write");
        idle_cycle();
        finish_test("unimplemented slots", start_errs);
    endtask

    task automatic test_gpio();
        logic [31:0] merged;
        logic [31:0] wdata;
        logic [3:0]  be;
        int          start_errs;
        start_errs = errors;
        for (int i = 0; i < 8; i++) begin
            be    = (i == 0) ? 4'hf : 4'($urandom);
            wdata = $urandom;
            write_word(be, periph_addr(PSEL_GPIO, 13'(GPIO_OUT) << 2), wdata);
            merged     = merge_lanes({16'h0, gpio_model}, wdata, be);
            gpio_model = merged[15:0]; // upper lanes have no register.
            if (gpio_o !== gpio_model) begin
                report_error($sformatf("gpio_o is %h, expected %h", gpio_o, gpio_model));
            end
            check_read(periph_addr(PSEL_GPIO, 13'(GPIO_OUT) << 2),
                       {16'h0, gpio_model}, "gpio out");
        end
        for (int i = 0; i < 4; i++) begin
            gpio_i = 16'($urandom);
            check_read(periph_addr(PSEL_GPIO, 13'(GPIO_IN) << 2), {16'h0, gpio_i}, "gpio in");
        end
        idle_cycle();
        finish_test("gpio", start_errs);
    endtask

    task automatic test_timer();
        int unsigned cmp;
        int unsigned load;
        int unsigned waited;
        int          start_errs;
        start_errs = errors;
        cmp = 16 + $urandom_range(47); // room for the steps before the next match.
        write_word(4'hf, periph_addr(PSEL_TIMER, 13'(TMR_COMPARE) << 2), cmp);
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_COMPARE) << 2), cmp, "timer compare");
        write_word(4'h1, periph_addr(PSEL_TIMER, 13'(TMR_CTRL) << 2), 32'h3);
        drive_data_idle();
        waited = 0;
        while (irq_o !== 1'b1 && waited < cmp + 4) begin
            @(negedge clk_i);
            waited++;
        end
        if (irq_o !== 1'b1) begin
            $display("timeout: irq_o did not rise within %0d cycles of enabling the timer",
                     cmp + 4);
            errors++;
        end
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_STATUS) << 2), 32'h1, "timer status");
        irq_ack_i = 1'b1;
        idle_cycle();
        irq_ack_i = 1'b0;
        if (irq_o !== 1'b0) report_error("irq_o still high after acknowledge");
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_STATUS) << 2), 32'h0, "timer status");
        // loaded value reads back once, then counts on.
        load = $urandom_range(cmp - 3);
        write_word(4'hf, periph_addr(PSEL_TIMER, 13'(TMR_COUNT) << 2), load);
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_COUNT) << 2), load, "timer count");
        check_read(periph_addr(PSEL_TIMER, 13'(TMR_COUNT) << 2), load + 1, "timer count");
        write_word(4'h1, periph_addr(PSEL_TIMER, 13'(TMR_CTRL) << 2), 32'h0);
        idle_cycle();
        finish_test("timer", start_errs);
    endtask

    initial begin
        void'($urandom(SEED));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        gpio_model   = '0;
        imem_known   = 0;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        irq_ack_i    = 1'b0;
        gpio_i       = '0;
        drive_data_idle();
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;

        test_reset_strobes();
        test_data_mem();
        test_instr_mem();
        test_empty_slots();
        test_gpio();
        test_timer();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
design/soc_pkg.sv
design/data_mem.sv
design/instr_mem.sv
design/timer.sv
design/gpio.sv
design/periph_bus.sv
verification/tb_periph_bus.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --timing -Wno-fatal
TOP     := tb_periph_bus
RTL_TOP := periph_bus
FLIST   := flist.f
OBJ_DIR := obj_dir
LOG     := sim.log

SRCS := $(shell grep -v '^+' $(FLIST)) include/soc_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run did not complete, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
